// File: project.f
hw/led_i2c_pkg.sv
hw/i2c_bit_engine.sv
hw/i2c_xfer_ctrl.sv
hw/pwm_reg_bank.sv
hw/pwm_channel.sv
hw/led_i2c_top.sv
verif/tb_led_i2c.sv

// File: verif/tb_led_i2c.sv
// Testbench for the I2C LED dimmer with a bit-banged I2C controller and PWM duty measurement
`timescale 1ns/100ps

module tb_led_i2c;

	localparam logic [6:0] DEV_ADDR = 7'h42;
	localparam int NUM_CH = 4;
	// SCL half-period in clk cycles
	localparam int HALF = 20;
	localparam int PERIOD = 65536;
	// Measurements in the whole run, and a generous budget of transfer cycles before each
	localparam int NUM_MEAS = 8;
	localparam int XFER_CYCLES = 20000;
	localparam int WATCHDOG_CYCLES = NUM_MEAS * (3 * PERIOD + XFER_CYCLES);

	logic clk;
	logic arst_n;
	logic scl_low;
	logic sda_low;
	wire scl;
	wire sda;
	wire [NUM_CH-1:0] led;

	// Open-drain bus with pull-ups
	assign scl = scl_low ? 1'b0 : 1'bz;
	assign sda = sda_low ? 1'b0 : 1'bz;
	pullup (scl);
	pullup (sda);

	// Expected duty and shadow bytes, per channel
	logic [15:0] exp_duty [NUM_CH];
	logic [7:0] exp_shadow [NUM_CH];
	logic [7:0] burst_data [16];

	// Position inside the PWM period, counted like the DUT counters
	logic [15:0] pwm_phase;

	int err_cnt;
	int err_at_start;
	int test_num;
	int failed_tests;
	bit bus_used;
	bit bus_busy;
	int seed;
	int unsigned rnd;

	led_i2c_top #(
		.DEV_ADDR (DEV_ADDR),
		.NUM_CH   (NUM_CH)
	) u_led_i2c_top (
		.clk    (clk),
		.arst_n (arst_n),
		.scl    (scl),
		.sda    (sda),
		.led    (led)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pwm_phase <= '0;
		else
			pwm_phase <= pwm_phase + 16'd1;
	end

	// Device must leave SDA alone until the controller opens the first transfer
	assert property (@(posedge clk) disable iff (!arst_n) (!bus_used) |-> (sda !== 1'b0))
	else begin
		err_cnt++;
		$display("SDA was pulled low before the first transfer");
	end

	// One SCL clock that starts and ends with SCL low
	// Data moves in the middle of the low half and is sampled in the middle of the high half
	task automatic clock_bit(input logic drive_low, output logic seen);
		repeat (HALF / 2) @(posedge clk);
		sda_low <= drive_low;
		repeat (HALF / 2) @(posedge clk);
		scl_low <= 1'b0;
		repeat (HALF / 2) @(posedge clk);
		seen = sda;
		repeat (HALF / 2) @(posedge clk);
		scl_low <= 1'b1;
	endtask

	// Start from an idle bus, or a repeated start inside a transfer
	task automatic bus_start;
		bus_used = 1'b1;
		if (bus_busy) begin
			repeat (HALF / 2) @(posedge clk);
			sda_low <= 1'b0;
			repeat (HALF / 2) @(posedge clk);
			scl_low <= 1'b0;
			repeat (HALF) @(posedge clk);
		end
		// SDA falls while SCL is high
		sda_low <= 1'b1;
		repeat (HALF) @(posedge clk);
		scl_low <= 1'b1;
		bus_busy = 1'b1;
	endtask

	task automatic bus_stop;
		repeat (HALF / 2) @(posedge clk);
		sda_low <= 1'b1;
		repeat (HALF / 2) @(posedge clk);
		scl_low <= 1'b0;
		repeat (HALF) @(posedge clk);
		// SDA rises while SCL is high
		sda_low <= 1'b0;
		repeat (HALF) @(posedge clk);
		bus_busy = 1'b0;
	endtask

	// Eight data bits MSB first, then the ACK slot with SDA released
	task automatic send_byte(input logic [7:0] data, output logic acked);
		logic seen;
		for (int i = 7; i >= 0; i--)
			clock_bit(~data[i], seen);
		clock_bit(1'b0, seen);
		acked = ~seen;
	endtask

	task automatic send_expect(input logic [7:0] data, input logic exp_ack);
		logic acked;
		send_byte(data, acked);
		assert (acked == exp_ack)
		else begin
			err_cnt++;
			if (exp_ack)
				$display("byte 0x%0h was not acknowledged by the device", data);
			else
				$display("byte 0x%0h was acknowledged but should have been refused", data);
		end
	endtask

	// Even byte parks in the shadow and odd byte commits both
	function automatic void model_write(input logic [7:0] addr, input logic [7:0] data);
		int ch;
		ch = addr >> 1;
		if (addr < 2 * NUM_CH) begin
			if (addr[0])
				exp_duty[ch] = {exp_shadow[ch], data};
			else
				exp_shadow[ch] = data;
		end
	endfunction

	// Address, pointer, then n bytes from burst_data with auto-increment
	task automatic write_burst(input logic [7:0] ptr, input int n, input bit do_stop);
		bus_start();
		send_expect({DEV_ADDR, 1'b0}, 1'b1);
		send_expect(ptr, 1'b1);
		for (int i = 0; i < n; i++) begin
			send_expect(burst_data[i], 1'b1);
			model_write(8'(ptr + i), burst_data[i]);
		end
		if (do_stop)
			bus_stop();
	endtask

	task automatic write_channel(input int ch, input logic [15:0] value);
		burst_data[0] = value[15:8];
		burst_data[1] = value[7:0];
		write_burst(8'(2 * ch), 2, 1'b1);
	endtask

	// Align to a period start, let a new duty settle for one period, count one period
	task automatic measure_check;
		int hi_cnt [NUM_CH];
		@(posedge clk);
		while (pwm_phase != 16'd0)
			@(posedge clk);
		repeat (PERIOD) @(posedge clk);
		for (int c = 0; c < NUM_CH; c++)
			hi_cnt[c] = 0;
		repeat (PERIOD) begin
			@(posedge clk);
			for (int c = 0; c < NUM_CH; c++)
				if (led[c] === 1'b1)
					hi_cnt[c]++;
		end
		for (int c = 0; c < NUM_CH; c++) begin
			assert (hi_cnt[c] == int'(exp_duty[c]))
			else begin
				err_cnt++;
				$display("error led[%0d] duty measured 0x%0h expected 0x%0h",
					c, hi_cnt[c], exp_duty[c]);
			end
		end
	endtask

	task automatic begin_test;
		test_num++;
		err_at_start = err_cnt;
	endtask

	task automatic end_test(input string name);
		if (err_cnt == err_at_start) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", test_num, name,
				err_cnt - err_at_start);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		scl_low = 1'b0;
		sda_low = 1'b0;
		bus_used = 1'b0;
		bus_busy = 1'b0;
		err_cnt = 0;
		test_num = 0;
		failed_tests = 0;
		seed = 84;
		rnd = $urandom(seed);
		for (int c = 0; c < NUM_CH; c++) begin
			exp_duty[c] = '0;
			exp_shadow[c] = '0;
		end
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;

		// LEDs dark after reset
		begin_test();
		measure_check();
		end_test("after reset");

		// Wrong address and read address with stray pointer and data bytes
		// Then an ACKed pointer and out of range byte
		begin_test();
		bus_start();
		send_expect({7'h43, 1'b0}, 1'b0);
		send_expect(8'h00, 1'b0);
		send_expect(8'h5a, 1'b0);
		send_expect(8'ha5, 1'b0);
		bus_stop();
		bus_start();
		send_expect({DEV_ADDR, 1'b1}, 1'b0);
		send_expect(8'h02, 1'b0);
		send_expect(8'h3c, 1'b0);
		send_expect(8'hc3, 1'b0);
		bus_stop();
		burst_data[0] = 8'(rnd);
		write_burst(8'h10, 1, 1'b1);
		measure_check();
		end_test("address ack");

		// Single channel writes including both extremes
		begin_test();
		write_channel(0, 16'($urandom));
		write_channel(1, 16'hffff);
		write_channel(2, 16'h0000);
		write_channel(3, 16'($urandom));
		measure_check();
		write_channel(0, 16'h0000);
		write_channel(1, 16'($urandom));
		write_channel(2, 16'hffff);
		measure_check();
		end_test("single channel write");

		// Full burst, then a lone high byte that must wait for its low byte
		begin_test();
		for (int i = 0; i < 2 * NUM_CH; i++)
			burst_data[i] = 8'($urandom);
		write_burst(8'h00, 2 * NUM_CH, 1'b1);
		measure_check();
		burst_data[0] = 8'($urandom);
		write_burst(8'h04, 1, 1'b1);
		measure_check();
		burst_data[0] = 8'($urandom);
		write_burst(8'h05, 1, 1'b1);
		measure_check();
		end_test("burst and shadow");

		// Out of range bytes, repeated start, then pointer wrap into channel 0
		begin_test();
		for (int i = 0; i < 4; i++)
			burst_data[i] = 8'($urandom);
		write_burst(8'h08, 4, 1'b0);
		burst_data[0] = 8'($urandom);
		burst_data[1] = 8'($urandom);
		write_burst(8'h06, 2, 1'b1);
		for (int i = 0; i < 4; i++)
			burst_data[i] = 8'($urandom);
		write_burst(8'hfe, 4, 1'b1);
		measure_check();
		end_test("out of range and repeated start");

		$display("%0d tests, %0d failed, %0d errors", test_num, failed_tests, err_cnt);
		if (err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: hw/led_i2c_top.sv
// I2C LED dimmer top level with the open-drain SDA pad, controller, register bank and PWM channels
`timescale 1ns/100ps

module led_i2c_top
	import led_i2c_pkg::*;
#(
	parameter logic [6:0]  DEV_ADDR = 7'h42,
	parameter int unsigned NUM_CH   = 4
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              scl,
	inout  wire               sda,
	output logic [NUM_CH-1:0] led
);

	// Bit engine to controller
	logic              sda_drive_low;
	logic              start_det;
	logic              stop_det;
	logic              byte_valid;
	logic [BYTE_W-1:0] rx_byte;
	logic              ack_en;

	// Controller to register bank
	logic              wr_en;
	logic [PTR_W-1:0]  wr_addr;
	logic [BYTE_W-1:0] wr_data;

	// Committed duty per channel
	logic [NUM_CH-1:0][DUTY_W-1:0] duty;

	// Open drain, pull low or let the bus pull-up win
	assign sda = sda_drive_low ? 1'b0 : 1'bz;

	i2c_bit_engine u_i2c_bit_engine (
		.clk           (clk),
		.arst_n        (arst_n),
		.scl_in        (scl),
		.sda_in        (sda),
		.ack_en        (ack_en),
		.sda_drive_low (sda_drive_low),
		.start_det     (start_det),
		.stop_det      (stop_det),
		.byte_valid    (byte_valid),
		.rx_byte       (rx_byte)
	);

	i2c_xfer_ctrl #(
		.DEV_ADDR (DEV_ADDR),
		.NUM_CH   (NUM_CH)
	) u_i2c_xfer_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.start_det  (start_det),
		.stop_det   (stop_det),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte),
		.ack_en     (ack_en),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	pwm_reg_bank #(
		.NUM_CH (NUM_CH)
	) u_pwm_reg_bank (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.duty    (duty)
	);

	// One PWM generator per LED
	for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
		pwm_channel u_pwm_channel (
			.clk    (clk),
			.arst_n (arst_n),
			.duty   (duty[c]),
			.led    (led[c])
		);
	end

endmodule

// File: hw/pwm_channel.sv
// Single LED PWM channel with a free-running 16-bit counter and registered compare
`timescale 1ns/100ps

module pwm_channel
	import led_i2c_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic [DUTY_W-1:0] duty,
	output logic              led
);

	localparam logic [DUTY_W-1:0] CNT_MAX = '1;

	logic [DUTY_W-1:0] cnt;

	// Duty used for the running period
	logic [DUTY_W-1:0] duty_q;

	// Counter wraps naturally after CNT_MAX
	// New duty is picked up only at the wrap, so no period is cut short
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt    <= '0;
			duty_q <= '0;
		end else begin
			cnt <= cnt + 1'b1;
			if (cnt == CNT_MAX)
				duty_q <= duty;
		end
	end

	// High for exactly duty_q counts of every 65536
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			led <= 1'b0;
		else
			led <= (cnt < duty_q);
	end

endmodule

// File: hw/pwm_reg_bank.sv
// Byte-addressed duty register bank with high-byte shadow and atomic 16-bit commit
`timescale 1ns/100ps

module pwm_reg_bank
	import led_i2c_pkg::*;
#(
	parameter int unsigned NUM_CH = 4
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           wr_en,
	input  logic [PTR_W-1:0]               wr_addr,
	input  logic [BYTE_W-1:0]              wr_data,
	output logic [NUM_CH-1:0][DUTY_W-1:0]  duty
);

	// Channel index is the pointer without its byte-select bit
	localparam int unsigned CH_W = PTR_W - 1;

	// High bytes waiting for their low byte
	logic [BYTE_W-1:0] shadow [NUM_CH];

	logic [CH_W-1:0] wr_ch;
	logic            wr_lo;

	// Even address is the high byte, odd is the low byte
	assign wr_ch = wr_addr[PTR_W-1:1];
	assign wr_lo = wr_addr[0];

	// High byte only parks in the shadow
	always_ff @(posedge clk) begin
		for (int c = 0; c < NUM_CH; c++) begin
			if (wr_en && !wr_lo && (wr_ch == CH_W'(c)))
				shadow[c] <= wr_data;
		end
	end

	// Low byte commits shadow and low byte together
	// LED never sees a half-updated value
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			duty <= '0;
		end else begin
			for (int c = 0; c < NUM_CH; c++) begin
				if (wr_en && wr_lo && (wr_ch == CH_W'(c)))
					duty[c] <= {shadow[c], wr_data};
			end
		end
	end

endmodule

// File: hw/i2c_xfer_ctrl.sv
// I2C transaction controller that matches the address, keeps the register pointer, and decides ACK
`timescale 1ns/100ps

module i2c_xfer_ctrl
	import led_i2c_pkg::*;
#(
	parameter logic [6:0]  DEV_ADDR = 7'h42,
	parameter int unsigned NUM_CH   = 4
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start_det,
	input  logic              stop_det,
	input  logic              byte_valid,
	input  logic [BYTE_W-1:0] rx_byte,
	output logic              ack_en,
	output logic              wr_en,
	output logic [PTR_W-1:0]  wr_addr,
	output logic [BYTE_W-1:0] wr_data
);

	// Bytes in the register map
	localparam int unsigned REG_BYTES = BYTES_PER_CH * NUM_CH;

	// Address byte we answer, write bit is 0
	localparam logic [BYTE_W-1:0] ADDR_WR = {DEV_ADDR, 1'b0};

	i2c_phase_t       phase;
	i2c_phase_t       phase_nxt;
	logic [PTR_W-1:0] ptr;

	// Decode of the current byte
	logic addr_match;
	logic in_range;
	logic byte_ack;

	// Read address or other device falls through to no match
	assign addr_match = (rx_byte == ADDR_WR);

	// Extra top bit keeps the compare safe for a full 256-byte map
	assign in_range = ({1'b0, ptr} < (PTR_W + 1)'(REG_BYTES));

	// Phase transitions
	always_comb begin
		phase_nxt = phase;
		if (start_det) begin
			phase_nxt = PH_ADDR;
		end else if (stop_det) begin
			phase_nxt = PH_IDLE;
		end else if (byte_valid) begin
			case (phase)
				PH_ADDR: phase_nxt = addr_match ? PH_PTR : PH_IGNORE;
				PH_PTR:  phase_nxt = PH_DATA;
				// Data stays in data, idle and ignore wait for a start
				default: phase_nxt = phase;
			endcase
		end
	end

	// ACK decision for the byte just received
	always_comb begin
		case (phase)
			PH_ADDR: byte_ack = addr_match;
			PH_PTR:  byte_ack = 1'b1;
			// Out of range data still gets ACKed
			PH_DATA: byte_ack = 1'b1;
			default: byte_ack = 1'b0;
		endcase
	end

	// Control state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase  <= PH_IDLE;
			ptr    <= '0;
			ack_en <= 1'b0;
			wr_en  <= 1'b0;
		end else begin
			phase <= phase_nxt;

			// Write strobe one cycle after byte_valid, in range only
			wr_en <= byte_valid & (phase == PH_DATA) & in_range;

			// Level held until the next byte, engine samples it on SCL fall
			if (byte_valid)
				ack_en <= byte_ack;

			// Pointer load, then auto-increment with wrap at 256
			if (byte_valid && (phase == PH_PTR))
				ptr <= PTR_W'(rx_byte);
			else if (byte_valid && (phase == PH_DATA))
				ptr <= ptr + 1'b1;
		end
	end

	// Write payload, qualified by wr_en
	always_ff @(posedge clk) begin
		if (byte_valid) begin
			wr_addr <= ptr;
			wr_data <= rx_byte;
		end
	end

endmodule

// File: hw/i2c_bit_engine.sv
// I2C target bit engine that synchronizes the bus, finds start and stop, shifts bytes in, drives ACK
`timescale 1ns/100ps

module i2c_bit_engine
	import led_i2c_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              scl_in,
	input  logic              sda_in,
	input  logic              ack_en,
	output logic              sda_drive_low,
	output logic              start_det,
	output logic              stop_det,
	output logic              byte_valid,
	output logic [BYTE_W-1:0] rx_byte
);

	// Bit 8 of each byte is the ACK slot
	localparam logic [3:0] ACK_SLOT = 4'd8;
	localparam logic [3:0] LAST_BIT = 4'd7;

	// Two-flop synchronizers plus one history flop per line
	logic scl_meta;
	logic scl_sync;
	logic scl_prev;
	logic sda_meta;
	logic sda_sync;
	logic sda_prev;

	// Decoded bus events, all in the clk domain
	logic scl_rise;
	logic scl_fall;
	logic start_cond;
	logic stop_cond;

	// Inside a transfer, between start and stop
	logic active;

	// Bit position 0 to 8
	logic [3:0] bit_cnt;

	// First seven bits of the current byte
	logic [BYTE_W-2:0] shift_q;

	// Idle bus is high on both lines, so reset to 1 to avoid false edges
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scl_meta <= 1'b1;
			scl_sync <= 1'b1;
			scl_prev <= 1'b1;
			sda_meta <= 1'b1;
			sda_sync <= 1'b1;
			sda_prev <= 1'b1;
		end else begin
			scl_meta <= scl_in;
			scl_sync <= scl_meta;
			scl_prev <= scl_sync;
			sda_meta <= sda_in;
			sda_sync <= sda_meta;
			sda_prev <= sda_sync;
		end
	end

	assign scl_rise = scl_sync & ~scl_prev;
	assign scl_fall = ~scl_sync & scl_prev;

	// SDA may only move while SCL is high for start and stop
	assign start_cond = scl_sync & scl_prev & sda_prev & ~sda_sync;
	assign stop_cond  = scl_sync & scl_prev & ~sda_prev & sda_sync;

	// Registered one-cycle strobes toward the controller
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			start_det  <= 1'b0;
			stop_det   <= 1'b0;
			byte_valid <= 1'b0;
		end else begin
			start_det  <= start_cond;
			stop_det   <= stop_cond;
			// Eighth data bit sampled on this rising edge
			byte_valid <= active & scl_rise & (bit_cnt == LAST_BIT);
		end
	end

	// Transfer window and bit position
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active  <= 1'b0;
			bit_cnt <= '0;
		end else begin
			if (start_cond) begin
				// Start or repeated start realigns the byte
				active  <= 1'b1;
				bit_cnt <= '0;
			end else if (stop_cond) begin
				active  <= 1'b0;
				bit_cnt <= '0;
			end else if (active && scl_rise) begin
				if (bit_cnt == ACK_SLOT)
					bit_cnt <= '0;
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// Shift data bits MSB first, the last bit completes rx_byte
	always_ff @(posedge clk) begin
		if (active && scl_rise && (bit_cnt < ACK_SLOT)) begin
			shift_q <= {shift_q[BYTE_W-3:0], sda_sync};
			if (bit_cnt == LAST_BIT)
				rx_byte <= {shift_q, sda_sync};
		end
	end

	// ACK driver
	// Falling edge after bit 7 opens the ACK slot, the next falling edge closes it
	// Only moves on SCL low, so it can never fake a start or stop
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sda_drive_low <= 1'b0;
		end else if (scl_fall) begin
			sda_drive_low <= active & (bit_cnt == ACK_SLOT) & ack_en;
		end
	end

endmodule

// File: hw/led_i2c_pkg.sv
// Shared widths, register map constants and controller phase type for the I2C LED dimmer
package led_i2c_pkg;

	// Data byte on the I2C bus
	localparam int unsigned BYTE_W = 8;

	// PWM duty value and counter width
	localparam int unsigned DUTY_W = 16;

	// Register pointer, wraps at 256
	localparam int unsigned PTR_W = 8;

	// Register map layout
	// Channel c has its high byte at 2c and its low byte at 2c+1
	localparam int unsigned BYTES_PER_CH = 2;

	// Transaction controller phases
	typedef enum logic [2:0] {
		// Bus free or between transfers
		PH_IDLE   = 3'd0,
		// Waiting for the address byte after a start
		PH_ADDR   = 3'd1,
		// Next byte loads the register pointer
		PH_PTR    = 3'd2,
		// Data bytes, written with auto-increment
		PH_DATA   = 3'd3,
		// Not addressed, stay off the bus until the next start
		PH_IGNORE = 3'd4
	} i2c_phase_t;

endpackage
